//--- exe_pkg.sv
// execute stage definitions
// opcodes, CSR addresses and the micro-op and result structs shared by all blocks
package exe_pkg;

  parameter int XLEN   = 64;
  parameter int CSR_AW = 12;

  // ----------------------------------------
  // opcodes
  // ----------------------------------------
  typedef enum logic [7:0] {
    INST_NOP    = 8'd0,
    INST_ADD    = 8'd1,
    INST_ADDI   = 8'd2,
    INST_SUB    = 8'd3,
    INST_ADDIW  = 8'd4,
    INST_SUBW   = 8'd5,
    INST_AND    = 8'd6,
    INST_ANDI   = 8'd7,
    INST_OR     = 8'd8,
    INST_ORI    = 8'd9,
    INST_XOR    = 8'd10,
    INST_XORI   = 8'd11,
    INST_SLL    = 8'd12,
    INST_SLLI   = 8'd13,
    INST_SLLW   = 8'd14,
    INST_SLLIW  = 8'd15,
    INST_SRL    = 8'd16,
    INST_SRLI   = 8'd17,
    INST_SRLW   = 8'd18,
    INST_SRLIW  = 8'd19,
    INST_SRA    = 8'd20,
    INST_SRAI   = 8'd21,
    INST_SRAW   = 8'd22,
    INST_SRAIW  = 8'd23,
    INST_SLT    = 8'd24,
    INST_SLTI   = 8'd25,
    INST_SLTU   = 8'd26,
    INST_SLTIU  = 8'd27,
    INST_LUI    = 8'd28,
    INST_AUIPC  = 8'd29,
    INST_JAL    = 8'd30,
    INST_JALR   = 8'd31,
    INST_BEQ    = 8'd32,
    INST_BNE    = 8'd33,
    INST_BLT    = 8'd34,
    INST_BGE    = 8'd35,
    INST_BLTU   = 8'd36,
    INST_BGEU   = 8'd37,
    INST_CSRRW  = 8'd38,
    INST_CSRRS  = 8'd39,
    INST_CSRRC  = 8'd40,
    INST_CSRRWI = 8'd41,
    INST_CSRRSI = 8'd42,
    INST_CSRRCI = 8'd43
  } exe_op_e;

  // ----------------------------------------
  // machine mode CSR addresses
  // ----------------------------------------
  parameter logic [CSR_AW-1:0] CSR_MSTATUS  = 12'h300;
  parameter logic [CSR_AW-1:0] CSR_MSCRATCH = 12'h340;
  parameter logic [CSR_AW-1:0] CSR_MEPC     = 12'h341;
  parameter logic [CSR_AW-1:0] CSR_MCYCLE   = 12'hB00;

  typedef struct packed {
    exe_op_e           opcode;
    logic [XLEN-1:0]   op1;       // rs1, pc for auipc/jal, zimm for csr imm forms
    logic [XLEN-1:0]   op2;       // rs2, immediate, or csr address in the low bits
    logic [XLEN-1:0]   op3;       // branch/jal target, link value for jalr
  } exe_uop_t;

  typedef struct packed {
    logic [XLEN-1:0]   rd_wdata;
    logic              jmp;
    logic [XLEN-1:0]   jmp_addr;
    logic              skip_cmt;  // op must not be counted as retired
  } exe_result_t;

endpackage

//--- ex_issue.sv
// issue latch of the execute stage
// registers the incoming micro-op and drops the one that follows a taken redirect
`timescale 1ns/1ps

module ex_issue import exe_pkg::*; (
  input  logic      clock,
  input  logic      i_rst,
  input  logic      i_valid,
  input  exe_uop_t  i_uop,
  input  logic      i_redirect,
  output logic      o_valid,
  output exe_uop_t  o_uop
);

  logic capture;

  // the op behind a taken jump is on the wrong path
  assign capture = i_valid & ~i_redirect;

  // ----------------------------------------
  // valid bit
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end
    else begin
      o_valid <= capture;
    end
  end

  // ----------------------------------------
  // payload
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (capture) begin
      o_uop <= i_uop;  // held while idle, o_valid tells whether it counts
    end
  end

endmodule

//--- exe_alu.sv
// execute unit
// integer results, branch resolution and CSR read-modify-write data, all combinational
`timescale 1ns/1ps

module exe_alu import exe_pkg::*; (
  input  logic               i_valid,
  input  exe_uop_t           i_uop,
  input  logic [XLEN-1:0]    i_csr_rdata,
  output logic [CSR_AW-1:0]  o_csr_addr,
  output logic               o_csr_ren,
  output logic               o_csr_wen,
  output logic [XLEN-1:0]    o_csr_wdata,
  output exe_result_t        o_res,
  output logic               o_redirect
);

  exe_op_e            opcode;
  logic [XLEN-1:0]    op1;
  logic [XLEN-1:0]    op2;
  logic [XLEN-1:0]    op3;
  logic [XLEN-1:0]    sum;
  logic [XLEN-1:0]    diff;
  logic [31:0]        sll_w;
  logic [31:0]        srl_w;
  logic signed [31:0] sra_w;
  logic               lt_s;
  logic               lt_u;
  logic               eq;
  logic               inst_csr;
  logic               csr_set_clr;
  logic [XLEN-1:0]    rd_wdata;
  logic               jmp;
  logic [XLEN-1:0]    jmp_addr;

  function automatic logic [XLEN-1:0] sext_w(input logic [31:0] val);
    sext_w = {{(XLEN-32){val[31]}}, val};
  endfunction

  assign opcode = i_uop.opcode;
  assign op1    = i_uop.op1;
  assign op2    = i_uop.op2;
  assign op3    = i_uop.op3;

  assign sum   = op1 + op2;
  assign diff  = op1 - op2;
  assign sll_w = op1[31:0] << op2[4:0];
  assign srl_w = op1[31:0] >> op2[4:0];
  assign sra_w = $signed(op1[31:0]) >>> op2[4:0];
  assign lt_s  = $signed(op1) < $signed(op2);
  assign lt_u  = op1 < op2;
  assign eq    = op1 == op2;

  // ----------------------------------------
  // result
  // ----------------------------------------
  always_comb begin
    rd_wdata = '0;
    if (i_valid) begin
      case (opcode)
        INST_ADD, INST_ADDI                 : rd_wdata = sum;
        INST_SUB                            : rd_wdata = diff;
        INST_ADDIW                          : rd_wdata = sext_w(sum[31:0]);
        INST_SUBW                           : rd_wdata = sext_w(diff[31:0]);
        INST_AND, INST_ANDI                 : rd_wdata = op1 & op2;
        INST_OR, INST_ORI                   : rd_wdata = op1 | op2;
        INST_XOR, INST_XORI                 : rd_wdata = op1 ^ op2;
        INST_SLL, INST_SLLI                 : rd_wdata = op1 << op2[5:0];
        INST_SLLW, INST_SLLIW               : rd_wdata = sext_w(sll_w);
        INST_SRL, INST_SRLI                 : rd_wdata = op1 >> op2[5:0];
        INST_SRLW, INST_SRLIW               : rd_wdata = sext_w(srl_w);
        INST_SRA, INST_SRAI                 : rd_wdata = $signed(op1) >>> op2[5:0];
        INST_SRAW, INST_SRAIW               : rd_wdata = sext_w(sra_w);
        INST_SLT, INST_SLTI                 : rd_wdata = {{(XLEN-1){1'b0}}, lt_s};
        INST_SLTU, INST_SLTIU               : rd_wdata = {{(XLEN-1){1'b0}}, lt_u};
        INST_LUI                            : rd_wdata = op1;  // decoder places the upper immediate in op1
        INST_AUIPC, INST_JAL                : rd_wdata = sum;  // pc plus offset, or pc plus 4 for the link
        INST_JALR                           : rd_wdata = op3;
        INST_CSRRW, INST_CSRRS, INST_CSRRC,
        INST_CSRRWI, INST_CSRRSI, INST_CSRRCI : rd_wdata = i_csr_rdata;  // old csr value
        default                             : rd_wdata = '0;
      endcase
    end
  end

  // ----------------------------------------
  // branch and jump resolution
  // ----------------------------------------
  always_comb begin
    jmp      = 1'b0;
    jmp_addr = '0;
    if (i_valid) begin
      case (opcode)
        INST_BEQ  : jmp = eq;
        INST_BNE  : jmp = ~eq;
        INST_BLT  : jmp = lt_s;
        INST_BGE  : jmp = ~lt_s;
        INST_BLTU : jmp = lt_u;
        INST_BGEU : jmp = ~lt_u;
        INST_JAL  : jmp = 1'b1;
        INST_JALR : jmp = 1'b1;
        default   : jmp = 1'b0;
      endcase
      case (opcode)
        INST_JALR                      : jmp_addr = sum & ~{{(XLEN-1){1'b0}}, 1'b1};
        INST_JAL, INST_BEQ, INST_BNE,
        INST_BLT, INST_BGE, INST_BLTU,
        INST_BGEU                      : jmp_addr = op3;
        default                        : jmp_addr = '0;
      endcase
    end
  end

  assign o_redirect = jmp & i_valid;

  // ----------------------------------------
  // csr access
  // ----------------------------------------
  assign inst_csr = (opcode == INST_CSRRW)  | (opcode == INST_CSRRS)  |
                    (opcode == INST_CSRRC)  | (opcode == INST_CSRRWI) |
                    (opcode == INST_CSRRSI) | (opcode == INST_CSRRCI);

  assign csr_set_clr = (opcode == INST_CSRRS)  | (opcode == INST_CSRRC) |
                       (opcode == INST_CSRRSI) | (opcode == INST_CSRRCI);

  assign o_csr_addr = (i_valid & inst_csr) ? op2[CSR_AW-1:0] : '0;
  assign o_csr_ren  = i_valid & inst_csr;
  // set or clear with a zero mask is a pure read and leaves mcycle counting
  assign o_csr_wen  = i_valid & inst_csr & ~(csr_set_clr & (op1 == '0));

  always_comb begin
    o_csr_wdata = '0;
    if (i_valid) begin
      case (opcode)
        INST_CSRRW, INST_CSRRWI : o_csr_wdata = op1;
        INST_CSRRS, INST_CSRRSI : o_csr_wdata = i_csr_rdata | op1;
        INST_CSRRC, INST_CSRRCI : o_csr_wdata = i_csr_rdata & ~op1;
        default                 : o_csr_wdata = '0;
      endcase
    end
  end

  assign o_res.rd_wdata = rd_wdata;
  assign o_res.jmp      = jmp;
  assign o_res.jmp_addr = jmp_addr;
  assign o_res.skip_cmt = o_csr_ren & (o_csr_addr == CSR_MCYCLE);

endmodule

//--- csr_file.sv
// machine mode CSR file
// mstatus, mscratch, mepc and a free-running mcycle with combinational read
`timescale 1ns/1ps

module csr_file import exe_pkg::*; #(
  parameter logic [XLEN-1:0] MSTATUS_WMASK = '1
) (
  input  logic               clock,
  input  logic               i_rst,
  input  logic [CSR_AW-1:0]  i_addr,
  input  logic               i_ren,
  input  logic               i_wen,
  input  logic [XLEN-1:0]    i_wdata,
  output logic [XLEN-1:0]    o_rdata
);

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mscratch;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcycle;
  logic            mcycle_wr;

  assign mcycle_wr = i_wen & (i_addr == CSR_MCYCLE);

  // ----------------------------------------
  // read
  // ----------------------------------------
  always_comb begin
    o_rdata = '0;
    if (i_ren) begin
      case (i_addr)
        CSR_MSTATUS  : o_rdata = mstatus;
        CSR_MSCRATCH : o_rdata = mscratch;
        CSR_MEPC     : o_rdata = mepc;
        CSR_MCYCLE   : o_rdata = mcycle;
        default      : o_rdata = '0;  // unimplemented address
      endcase
    end
  end

  // ----------------------------------------
  // write
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (i_rst) begin
      mstatus  <= '0;
      mscratch <= '0;
      mepc     <= '0;
    end
    else if (i_wen) begin
      case (i_addr)
        CSR_MSTATUS  : mstatus  <= i_wdata & MSTATUS_WMASK;  // read-only bits stay 0
        CSR_MSCRATCH : mscratch <= i_wdata;
        CSR_MEPC     : mepc     <= i_wdata;
        default      : ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (i_rst) begin
      mcycle <= '0;
    end
    else if (mcycle_wr) begin
      mcycle <= i_wdata;
    end
    else begin
      mcycle <= mcycle + 1'b1;
    end
  end

endmodule

//--- ex_commit.sv
// commit register of the execute stage
// holds the result for one cycle and counts retired instructions
`timescale 1ns/1ps

module ex_commit import exe_pkg::*; (
  input  logic             clock,
  input  logic             i_rst,
  input  logic             i_valid,
  input  exe_result_t      i_res,
  output logic             o_valid,
  output exe_result_t      o_res,
  output logic [XLEN-1:0]  o_retire_cnt
);

  logic retire;

  assign retire = i_valid & ~i_res.skip_cmt;

  // ----------------------------------------
  // valid and retire counter
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (i_rst) begin
      o_valid      <= 1'b0;
      o_retire_cnt <= '0;
    end
    else begin
      o_valid <= i_valid;
      if (retire) begin
        o_retire_cnt <= o_retire_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (i_valid) begin
      o_res <= i_res;
    end
  end

endmodule

//--- exe_stage.sv
// execute stage top
// issue latch, execute unit with CSR file, and commit register
`timescale 1ns/1ps

module exe_stage import exe_pkg::*; #(
  parameter logic [XLEN-1:0] MSTATUS_WMASK = '1
) (
  input  logic             clock,
  input  logic             i_rst,
  input  logic             i_valid,
  input  exe_uop_t         i_uop,
  output logic             o_valid,
  output exe_result_t      o_res,
  output logic [XLEN-1:0]  o_retire_cnt
);

  logic               issue_valid;
  exe_uop_t           issue_uop;
  logic [CSR_AW-1:0]  csr_addr;
  logic               csr_ren;
  logic               csr_wen;
  logic [XLEN-1:0]    csr_wdata;
  logic [XLEN-1:0]    csr_rdata;
  exe_result_t        alu_res;
  logic               redirect;

  ex_issue u_ex_issue (
    .clock      (clock),
    .i_rst      (i_rst),
    .i_valid    (i_valid),
    .i_uop      (i_uop),
    .i_redirect (redirect),
    .o_valid    (issue_valid),
    .o_uop      (issue_uop)
  );

  exe_alu u_exe_alu (
    .i_valid     (issue_valid),
    .i_uop       (issue_uop),
    .i_csr_rdata (csr_rdata),
    .o_csr_addr  (csr_addr),
    .o_csr_ren   (csr_ren),
    .o_csr_wen   (csr_wen),
    .o_csr_wdata (csr_wdata),
    .o_res       (alu_res),
    .o_redirect  (redirect)
  );

  csr_file #(
    .MSTATUS_WMASK (MSTATUS_WMASK)
  ) u_csr_file (
    .clock   (clock),
    .i_rst   (i_rst),
    .i_addr  (csr_addr),
    .i_ren   (csr_ren),
    .i_wen   (csr_wen),
    .i_wdata (csr_wdata),
    .o_rdata (csr_rdata)
  );

  ex_commit u_ex_commit (
    .clock        (clock),
    .i_rst        (i_rst),
    .i_valid      (issue_valid),
    .i_res        (alu_res),
    .o_valid      (o_valid),
    .o_res        (o_res),
    .o_retire_cnt (o_retire_cnt)
  );

endmodule

//--- tb_exe_tests.svh
// directed tests and reference model for the execute stage testbench
`ifndef TB_EXE_TESTS_SVH
`define TB_EXE_TESTS_SVH

function automatic logic [XLEN-1:0] sext32(input logic [31:0] v);
  return {{32{v[31]}}, v};
endfunction

function automatic exe_result_t data_only(input logic [XLEN-1:0] v);
  exe_result_t r;
  r          = '0;
  r.rd_wdata = v;
  return r;
endfunction

function automatic exe_result_t alu_reference(input exe_op_e op, input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b,
                                              input logic [XLEN-1:0] c);
  exe_result_t r;
  r = '0;
  case (op)
    INST_ADD, INST_ADDI   : r.rd_wdata = a + b;
    INST_SUB              : r.rd_wdata = a - b;
    INST_ADDIW            : r.rd_wdata = sext32(a[31:0] + b[31:0]);
    INST_SUBW             : r.rd_wdata = sext32(a[31:0] - b[31:0]);
    INST_AND, INST_ANDI   : r.rd_wdata = a & b;
    INST_OR, INST_ORI     : r.rd_wdata = a | b;
    INST_XOR, INST_XORI   : r.rd_wdata = a ^ b;
    INST_SLL, INST_SLLI   : r.rd_wdata = a << b[5:0];
    INST_SLLW, INST_SLLIW : r.rd_wdata = sext32(a[31:0] << b[4:0]);
    INST_SRL, INST_SRLI   : r.rd_wdata = a >> b[5:0];
    INST_SRLW, INST_SRLIW : r.rd_wdata = sext32(a[31:0] >> b[4:0]);
    INST_SRA, INST_SRAI   : r.rd_wdata = $signed(a) >>> b[5:0];
    INST_SRAW, INST_SRAIW : r.rd_wdata = sext32($signed(a[31:0]) >>> b[4:0]);
    INST_SLT, INST_SLTI   : r.rd_wdata = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
    INST_SLTU, INST_SLTIU : r.rd_wdata = (a < b) ? 64'd1 : 64'd0;
    INST_LUI              : r.rd_wdata = a;
    INST_AUIPC            : r.rd_wdata = a + b;
    INST_JAL : begin
      r.rd_wdata = a + b;  // pc plus 4
      r.jmp      = 1'b1;
      r.jmp_addr = c;
    end
    INST_JALR : begin
      r.rd_wdata = c;
      r.jmp      = 1'b1;
      r.jmp_addr = (a + b) & ~64'd1;
    end
    INST_BEQ  : r.jmp = (a == b);
    INST_BNE  : r.jmp = (a != b);
    INST_BLT  : r.jmp = ($signed(a) < $signed(b));
    INST_BGE  : r.jmp = ($signed(a) >= $signed(b));
    INST_BLTU : r.jmp = (a < b);
    INST_BGEU : r.jmp = (a >= b);
    default   : r = '0;
  endcase
  if (op >= INST_BEQ && op <= INST_BGEU) begin
    r.jmp_addr = c;
  end
  return r;
endfunction

task automatic issue_alu(input exe_op_e op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic [XLEN-1:0] c);
  drive_uop(op, a, b, c);
  expect_result(alu_reference(op, a, b, c), 1'b1);
endtask

task automatic test_reset();
  @(negedge clock);
  check_value("o_valid after reset", XLEN'(o_valid), '0);
  check_value("retire count after reset", o_retire_cnt, '0);
endtask

task automatic test_alu_ops();
  for (int k = int'(INST_ADD); k <= int'(INST_AUIPC); k++) begin
    repeat (ALU_PAIRS) begin
      issue_alu(exe_op_e'(k), rand_word(), rand_word(), rand_word());
    end
  end
  drain();
endtask

task automatic test_branches();
  logic [XLEN-1:0] x;
  logic [XLEN-1:0] a_val[4];
  logic [XLEN-1:0] b_val[4];
  x     = rand_word() >> 2;
  a_val = '{x, x, x + 64'd9, -64'd1};
  b_val = '{x, x + 64'd9, x, 64'd1};  // equal, less, greater, then mixed signs
  for (int k = int'(INST_BEQ); k <= int'(INST_BGEU); k++) begin
    for (int p = 0; p < 4; p++) begin
      issue_alu(exe_op_e'(k), a_val[p], b_val[p], rand_word());
      idle(1);
    end
  end
  issue_alu(INST_JAL, x, 64'd4, rand_word());
  idle(1);
  issue_alu(INST_JALR, x | 64'd1, 64'd6, rand_word());  // odd sum, bit 0 must clear
  idle(1);
  drain();
endtask

task automatic test_squash();
  logic [XLEN-1:0] x;
  logic [XLEN-1:0] cnt_before;
  x          = rand_word();
  cnt_before = o_retire_cnt;
  issue_alu(INST_BEQ, x, x, rand_word());
  drive_uop(INST_ADD, x, x, '0);  // wrong path, never commits
  drain();
  check_value("retire count after squash", o_retire_cnt, cnt_before + 64'd1);
  issue_alu(INST_BNE, x, x, rand_word());
  issue_alu(INST_ADD, x, 64'd3, '0);
  drain();
  check_value("retire count after fall-through", o_retire_cnt, cnt_before + 64'd3);
endtask

task automatic test_csr_ops();
  logic [XLEN-1:0] model;
  logic [XLEN-1:0] src;
  logic [XLEN-1:0] nxt;
  exe_op_e         op;
  model = '0;  // mscratch is untouched since reset
  for (int k = int'(INST_CSRRW); k <= int'(INST_CSRRCI); k++) begin
    op  = exe_op_e'(k);
    src = rand_word();
    if (op >= INST_CSRRWI) begin
      src = src & 64'h1f;  // zimm is 5 bits
    end
    case (op)
      INST_CSRRW, INST_CSRRWI : nxt = src;
      INST_CSRRS, INST_CSRRSI : nxt = model | src;
      default                 : nxt = model & ~src;
    endcase
    drive_uop(op, src, XLEN'(CSR_MSCRATCH), '0);
    expect_result(data_only(model), 1'b1);
    model = nxt;
    drive_uop(INST_CSRRS, '0, XLEN'(CSR_MSCRATCH), '0);
    expect_result(data_only(model), 1'b1);
  end
  drain();
endtask

task automatic test_mcycle();
  int              gap;
  exe_result_t     r;
  logic [XLEN-1:0] cnt_before;
  gap        = 7;
  r          = '0;
  r.skip_cmt = 1'b1;
  seen_q.delete();
  cnt_before = o_retire_cnt;
  drive_uop(INST_CSRRS, '0, XLEN'(CSR_MCYCLE), '0);
  expect_result(r, 1'b0);
  idle(gap - 1);
  drive_uop(INST_CSRRS, '0, XLEN'(CSR_MCYCLE), '0);
  expect_result(r, 1'b0);
  drain();
  check_value("retire count after mcycle reads", o_retire_cnt, cnt_before);
  assert (seen_q.size() == 2) else begin
    err_cnt++;
    $display("mcycle test: expected two mcycle reads, saw %0d", seen_q.size());
  end
  if (seen_q.size() == 2) begin
    check_value("mcycle distance", seen_q[1] - seen_q[0], XLEN'(gap));
  end
endtask

`endif

//--- tb_exe_stage.sv
// testbench for the execute stage
// drives micro-ops, checks every commit against a queue of expected results
`timescale 1ns/1ps

module tb_exe_stage import exe_pkg::*; ();

  localparam int ALU_PAIRS  = 40;
  localparam int N_ALU_OPS  = int'(INST_AUIPC) - int'(INST_ADD) + 1;
  localparam int MAX_CYCLES = N_ALU_OPS * ALU_PAIRS + 400;  // alu stream plus the short tests

  typedef struct packed {
    exe_result_t res;
    logic        chk_data;  // low when rd_wdata is only known after the run
  } expect_t;

  logic             clock;
  logic             i_rst;
  logic             i_valid;
  exe_uop_t         i_uop;
  logic             o_valid;
  exe_result_t      o_res;
  logic [XLEN-1:0]  o_retire_cnt;

  expect_t          exp_q[$];
  logic [XLEN-1:0]  seen_q[$];
  logic [XLEN-1:0]  exp_retire = '0;
  logic [63:0]      rng_state = 64'd55;
  int               err_cnt = 0;
  int               check_cnt = 0;
  int               cycle_cnt = 0;

  exe_stage i_exe_stage (
    .clock        (clock),
    .i_rst        (i_rst),
    .i_valid      (i_valid),
    .i_uop        (i_uop),
    .o_valid      (o_valid),
    .o_res        (o_res),
    .o_retire_cnt (o_retire_cnt)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [63:0] lcg_next();
    rng_state = rng_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return rng_state;
  endfunction

  function automatic logic [XLEN-1:0] rand_word();
    logic [63:0] s1;
    logic [63:0] s2;
    s1 = lcg_next();
    s2 = lcg_next();
    return {s1[63:32], s2[63:32]};  // low lcg bits have short periods
  endfunction

  task automatic check_value(input string what, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic drive_uop(input exe_op_e op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [XLEN-1:0] c);
    @(posedge clock);
    i_valid <= 1'b1;
    i_uop   <= '{opcode: op, op1: a, op2: b, op3: c};
  endtask

  task automatic expect_result(input exe_result_t r, input logic chk);
    expect_t e;
    e.res      = r;
    e.chk_data = chk;
    exp_q.push_back(e);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clock);
      i_valid <= 1'b0;
    end
  endtask

  task automatic drain();
    idle(1);
    while (exp_q.size() != 0) begin
      @(negedge clock);
    end
    repeat (3) @(negedge clock);  // room for a stray commit of a dropped op
  endtask

  `include "tb_exe_tests.svh"

  // ----------------------------------------
  // commit checker
  // ----------------------------------------
  always @(negedge clock) begin : result_check
    expect_t e;
    if (o_valid) begin
      assert (exp_q.size() > 0) else begin
        err_cnt++;
        $display("%0t: a result was committed while no op was outstanding", $time);
      end
      if (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        if (e.chk_data) begin
          check_value("rd_wdata", o_res.rd_wdata, e.res.rd_wdata);
        end
        else begin
          seen_q.push_back(o_res.rd_wdata);
        end
        check_value("jmp", XLEN'(o_res.jmp), XLEN'(e.res.jmp));
        check_value("jmp_addr", o_res.jmp_addr, e.res.jmp_addr);
        check_value("skip_cmt", XLEN'(o_res.skip_cmt), XLEN'(e.res.skip_cmt));
        if (!e.res.skip_cmt) begin
          exp_retire = exp_retire + 64'd1;
        end
        check_value("retire count", o_retire_cnt, exp_retire);
      end
    end
  end

  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    i_rst   <= 1'b1;
    i_valid <= 1'b1;  // nops offered during reset must leave no trace
    i_uop   <= '0;
    repeat (5) @(posedge clock);
    i_rst   <= 1'b0;
    i_valid <= 1'b0;
    test_reset();
    test_alu_ops();
    test_branches();
    test_squash();
    test_csr_ops();
    test_mcycle();
    $display("checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end
    else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+.
exe_pkg.sv
ex_issue.sv
exe_alu.sv
csr_file.sv
ex_commit.sv
exe_stage.sv
tb_exe_stage.sv

//--- run.sh
#!/bin/sh
# build the execute stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_exe_stage
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_exe_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
  exit 1
fi
exit 0
